/* design/tune_pkg.sv */
package tune_pkg;

    // Register map, word aligned
    localparam logic [3:0] ADDR_CTRL   = 4'h0;
    localparam logic [3:0] ADDR_SHIFT  = 4'h4;
    localparam logic [3:0] ADDR_STATUS = 4'h8;

    localparam logic [4:0] TEMPO_SHIFT_RST = 5'd20; // 8 beats = 24'h800000
    localparam logic [2:0] PITCH_SHIFT_RST = 3'd0;

    typedef enum logic [1:0] {
        NOTE_D7,
        NOTE_E7,
        NOTE_F7,
        NOTE_A6
    } note_t;

    typedef enum logic [1:0] {
        IDLE,
        PLAY,   // Current note sounding
        GAP     // One silent cycle between notes
    } seq_state_t;

    localparam int MELODY_LEN = 8;

    localparam note_t MELODY_NOTE [MELODY_LEN] = '{
        NOTE_D7, NOTE_E7, NOTE_F7, NOTE_E7, NOTE_F7, NOTE_D7, NOTE_A6, NOTE_D7
    };

    localparam logic [3:0] MELODY_BEATS [MELODY_LEN] = '{
        4'd8, 4'd8, 4'd8, 4'd12, 4'd4, 4'd12, 4'd4, 4'd8
    };

    // Half-periods in 50 MHz clocks, in note_t order
    localparam logic [14:0] HALF_PERIOD [4] = '{15'd10642, 15'd9481, 15'd8949, 15'd14204};

    typedef struct packed {
        logic       start;       // One-cycle pulse
        logic       stop;        // One-cycle pulse
        logic [4:0] tempo_shift;
        logic [2:0] pitch_shift;
    } play_ctrl_t;

    typedef struct packed {
        logic       busy;
        logic [2:0] note_idx;
    } play_status_t;

    typedef struct packed {
        logic       load;        // First cycle of a note
        logic       sounding;
        note_t      note;
        logic [3:0] beats;
    } note_cmd_t;

endpackage

/* design/axil_tune_regs.sv */
`timescale 1ns/1ps

module axil_tune_regs import tune_pkg::*; (
    input  logic         clk,
    input  logic         note_rst_n,
    // Write address and data
    input  logic [3:0]   awaddr,
    input  logic         awvalid,
    output logic         awready,
    input  logic [31:0]  wdata,
    input  logic         wvalid,
    output logic         wready,
    // Write response
    output logic [1:0]   bresp,
    output logic         bvalid,
    input  logic         bready,
    // Read address
    input  logic [3:0]   araddr,
    input  logic         arvalid,
    output logic         arready,
    // Read data
    output logic [31:0]  rdata,
    output logic [1:0]   rresp,
    output logic         rvalid,
    input  logic         rready,
    input  play_status_t status,
    output play_ctrl_t   ctrl
);

    logic       wr_hs;
    logic       rd_hs;
    logic       start_q;
    logic       stop_q;
    logic [4:0] tempo_shift_q;
    logic [2:0] pitch_shift_q;

    assign wr_hs = awvalid & awready & wvalid & wready;
    assign rd_hs = arvalid & arready;

    assign bresp = 2'b00; // Always OKAY
    assign rresp = 2'b00;

    // Write channel, address and data taken together
    always_ff @(posedge clk or negedge note_rst_n) begin
        if (!note_rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (wr_hs) begin
                awready <= 1'b0;
                wready  <= 1'b0;
                bvalid  <= 1'b1;
            end else if (awvalid && wvalid && !awready && !bvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end
            if (bvalid && bready)
                bvalid <= 1'b0;
        end
    end

    // Register updates and control pulses
    always_ff @(posedge clk or negedge note_rst_n) begin
        if (!note_rst_n) begin
            start_q       <= 1'b0;
            stop_q        <= 1'b0;
            tempo_shift_q <= TEMPO_SHIFT_RST;
            pitch_shift_q <= PITCH_SHIFT_RST;
        end else begin
            start_q <= wr_hs && (awaddr == ADDR_CTRL) && wdata[0];
            stop_q  <= wr_hs && (awaddr == ADDR_CTRL) && wdata[1];
            if (wr_hs && (awaddr == ADDR_SHIFT)) begin
                tempo_shift_q <= wdata[4:0];
                pitch_shift_q <= wdata[10:8];
            end
        end
    end

    // Read channel, one response outstanding
    always_ff @(posedge clk or negedge note_rst_n) begin
        if (!note_rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (rd_hs) begin
                arready <= 1'b0;
                rvalid  <= 1'b1;
            end else if (arvalid && !arready && !rvalid) begin
                arready <= 1'b1;
            end
            if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            case (araddr)
                ADDR_SHIFT:  rdata <= {21'd0, pitch_shift_q, 3'd0, tempo_shift_q};
                ADDR_STATUS: rdata <= {25'd0, status.note_idx, 3'd0, status.busy};
                default:     rdata <= 32'd0; // CTRL and unmapped
            endcase
        end
    end

    assign ctrl.start       = start_q;
    assign ctrl.stop        = stop_q;
    assign ctrl.tempo_shift = tempo_shift_q;
    assign ctrl.pitch_shift = pitch_shift_q;

endmodule

/* design/tune_sequencer.sv */
`timescale 1ns/1ps

module tune_sequencer import tune_pkg::*; (
    input  logic         clk,
    input  logic         note_rst_n,
    input  play_ctrl_t   ctrl,
    input  logic         dur_done,
    output note_cmd_t    cmd,
    output play_status_t status
);

    seq_state_t state;
    logic [2:0] idx;    // Position in the melody
    logic       load;

    // Walks the melody table, one PLAY and one GAP per note
    always_ff @(posedge clk or negedge note_rst_n) begin
        if (!note_rst_n) begin
            state <= IDLE;
            idx   <= 3'd0;
            load  <= 1'b0;
        end else begin
            load <= 1'b0;
            if (ctrl.stop) begin
                state <= IDLE;  // Abort from anywhere
            end else begin
                case (state)
                    IDLE: begin
                        if (ctrl.start) begin
                            state <= PLAY;
                            idx   <= 3'd0;
                            load  <= 1'b1;
                        end
                    end
                    PLAY: begin
                        if (dur_done)
                            state <= GAP;
                    end
                    GAP: begin
                        // Last note done, back to rest
                        if (idx == 3'(MELODY_LEN - 1)) begin
                            state <= IDLE;
                        end else begin
                            idx   <= idx + 3'd1;
                            state <= PLAY;
                            load  <= 1'b1;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // Note command to both timers
    assign cmd.load     = load;
    assign cmd.sounding = (state == PLAY);
    assign cmd.note     = MELODY_NOTE[idx];
    assign cmd.beats    = MELODY_BEATS[idx];

    assign status.busy     = (state != IDLE);
    assign status.note_idx = idx;

endmodule

/* design/dur_timer.sv */
`timescale 1ns/1ps

module dur_timer import tune_pkg::*; (
    input  logic      clk,
    input  logic      note_rst_n,
    input  note_cmd_t cmd,
    input  logic [4:0] tempo_shift,
    output logic      dur_done
);

    logic [23:0] note_len;   // Note length in clocks
    logic [23:0] remain_cnt; // Cycles left after the current one

    assign note_len = 24'(cmd.beats) << tempo_shift;

    always_ff @(posedge clk or negedge note_rst_n) begin
        if (!note_rst_n) begin
            remain_cnt <= 24'd0;
        end else if (cmd.load) begin
            remain_cnt <= note_len - 24'd1; // Load cycle is the first one
        end else if (cmd.sounding && remain_cnt != 24'd0) begin
            remain_cnt <= remain_cnt - 24'd1;
        end
    end

    // High on the last sounding cycle only
    assign dur_done = cmd.sounding & ~cmd.load & (remain_cnt == 24'd1);

endmodule

/* design/note_tone_gen.sv */
`timescale 1ns/1ps

module note_tone_gen import tune_pkg::*; (
    input  logic       clk,
    input  logic       note_rst_n,
    input  note_cmd_t  cmd,
    input  logic [2:0] pitch_shift,
    output logic       piezo,
    output logic       piezo_n
);

    logic [14:0] half_next;
    logic [14:0] half_q;    // Half-period of the note playing
    logic [14:0] period_cnt;
    logic        wave;

    // Each pitch_shift step is one octave up
    assign half_next = HALF_PERIOD[cmd.note] >> pitch_shift;

    always_ff @(posedge clk or negedge note_rst_n) begin
        if (!note_rst_n) begin
            half_q     <= 15'd0;
            period_cnt <= 15'd0;
            wave       <= 1'b0;
        end else if (cmd.load) begin
            half_q     <= half_next;
            period_cnt <= 15'd1; // Load cycle counts as zero
            wave       <= 1'b0;
        end else if (!cmd.sounding) begin
            period_cnt <= 15'd0;
            wave       <= 1'b0;
        end else if (period_cnt == half_q - 15'd1) begin
            period_cnt <= 15'd0;
            wave       <= ~wave;
        end else begin
            period_cnt <= period_cnt + 15'd1;
        end
    end

    // Rest levels whenever the note is not sounding
    assign piezo   = cmd.sounding & wave;
    assign piezo_n = ~piezo;

endmodule

/* design/tune_player.sv */
`timescale 1ns/1ps

module tune_player import tune_pkg::*; (
    input  logic        clk,
    input  logic        note_rst_n,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic        piezo,
    output logic        piezo_n
);

    play_ctrl_t   ctrl;
    play_status_t status;
    note_cmd_t    cmd;
    logic         dur_done;

    axil_tune_regs regs_inst (
        .clk        (clk),
        .note_rst_n (note_rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .status     (status),
        .ctrl       (ctrl)
    );

    tune_sequencer seq_inst (
        .clk        (clk),
        .note_rst_n (note_rst_n),
        .ctrl       (ctrl),
        .dur_done   (dur_done),
        .cmd        (cmd),
        .status     (status)
    );

    dur_timer dur_inst (
        .clk         (clk),
        .note_rst_n  (note_rst_n),
        .cmd         (cmd),
        .tempo_shift (ctrl.tempo_shift),
        .dur_done    (dur_done)
    );

    note_tone_gen tone_inst (
        .clk         (clk),
        .note_rst_n  (note_rst_n),
        .cmd         (cmd),
        .pitch_shift (ctrl.pitch_shift),
        .piezo       (piezo),
        .piezo_n     (piezo_n)
    );

endmodule

/* tests/tune_player_tb.sv */
`timescale 1ns/1ps

module tune_player_tb;

    localparam int CLK_PERIOD = 40;
    localparam int TEMPO = 6;
    localparam int PITCH = 5;
    localparam logic [3:0] ADDR_CTRL   = 4'h0;
    localparam logic [3:0] ADDR_SHIFT  = 4'h4;
    localparam logic [3:0] ADDR_STATUS = 4'h8;
    localparam int HALF_CLKS [4] = '{10642, 9481, 8949, 14204}; // D7, E7, F7, A6
    localparam int MELODY [8] = '{0, 1, 2, 1, 2, 0, 3, 0};      // Indexes into HALF_CLKS
    localparam int BEATS [8] = '{8, 8, 8, 12, 4, 12, 4, 8};
    localparam int TUNE_CYCLES = (64 << TEMPO) + 8;             // 64 beats plus eight gaps
    // Three plays of the tune and the bus traffic, plus 20 percent
    localparam int WATCHDOG_NS = (3 * TUNE_CYCLES + 2000) * CLK_PERIOD * 12 / 10;

    logic        clk;
    logic        note_rst_n;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        piezo;
    logic        piezo_n;

    int          errors;
    int          cyc;        // Rising edges seen so far
    logic        last_piezo;
    logic [31:0] rng_state;
    int          edge_q[$];  // Cycles where piezo changed
    int          exp_q[$];

    tune_player tune_player_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish in the expected time");
        $display("test failed");
        $finish;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Edge capture and complement check, sampled mid-cycle
    always @(negedge clk) begin
        if (piezo !== last_piezo)
            edge_q.push_back(cyc);
        last_piezo = piezo;
        if (piezo_n !== ~piezo)
            report_mismatch("piezo_n", {31'd0, ~piezo}, {31'd0, piezo_n});
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_delay();
        rng_state = xorshift32(rng_state);
        return int'(rng_state[1:0]);
    endfunction

    // First cycle of note idx, with index 8 giving the cycle after the last gap
    function automatic int note_start(input int load_cyc, input int tempo, input int idx);
        int s;
        s = load_cyc;
        for (int i = 0; i < idx; i++)
            s += (BEATS[i] << tempo) + 1;
        return s;
    endfunction

    // Expected piezo edges: every half-period after load, and a fall into the gap if high
    function automatic void build_expected(input int load_cyc, input int tempo, input int pitch);
        int s;
        int len;
        int half;
        exp_q.delete();
        for (int i = 0; i < 8; i++) begin
            s    = note_start(load_cyc, tempo, i);
            len  = BEATS[i] << tempo;
            half = HALF_CLKS[MELODY[i]] >> pitch;
            for (int t = half; t < len; t += half)
                exp_q.push_back(s + t);
            if (((len - 1) / half) % 2 == 1)
                exp_q.push_back(s + len);
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("Mismatch %s: expected 0x%0h, got 0x%0h", name, exp, got);
    endtask

    task automatic wait_until_cycle(input int target);
        while (cyc < target) @(negedge clk);
    endtask

    // hs_cyc is the cycle just before the write handshake edge
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output int hs_cyc);
        int delay;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        hs_cyc = cyc;
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        delay = rand_delay();
        repeat (delay) @(posedge clk);
        bready <= 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        if (bresp !== 2'b00) report_mismatch("bresp", 32'd0, {30'd0, bresp});
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        int delay;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        delay = rand_delay();
        repeat (delay) @(posedge clk);
        rready <= 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        if (rresp !== 2'b00) report_mismatch("rresp", 32'd0, {30'd0, rresp});
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // Load comes two cycles after the start write handshake
    task automatic play_tune(input int tempo, input int pitch, output int load_cyc);
        int hs;
        axi_write(ADDR_SHIFT, 32'((pitch << 8) | tempo), hs);
        edge_q.delete();
        axi_write(ADDR_CTRL, 32'd1, hs);
        load_cyc = hs + 2;
    endtask

    task automatic verify_reset_state();
        logic [31:0] rd;
        int          hs;
        @(negedge clk);
        if (piezo !== 1'b0) report_mismatch("piezo", 32'd0, {31'd0, piezo});
        if (piezo_n !== 1'b1) report_mismatch("piezo_n", 32'd1, {31'd0, piezo_n});
        if (awready !== 1'b0) report_mismatch("awready", 32'd0, {31'd0, awready});
        if (wready !== 1'b0) report_mismatch("wready", 32'd0, {31'd0, wready});
        if (arready !== 1'b0) report_mismatch("arready", 32'd0, {31'd0, arready});
        if (bvalid !== 1'b0) report_mismatch("bvalid", 32'd0, {31'd0, bvalid});
        if (rvalid !== 1'b0) report_mismatch("rvalid", 32'd0, {31'd0, rvalid});
        axi_read(ADDR_STATUS, rd);
        if (rd !== 32'd0) report_mismatch("status", 32'd0, rd);
        axi_read(ADDR_SHIFT, rd);
        if (rd !== 32'h14) report_mismatch("shift", 32'h14, rd);
        axi_read(4'hC, rd);
        if (rd !== 32'd0) report_mismatch("unmapped_read", 32'd0, rd);
        axi_write(4'hC, 32'hFFFF_FFFF, hs); // Must not reach SHIFT
        axi_read(ADDR_SHIFT, rd);
        if (rd !== 32'h14) report_mismatch("shift", 32'h14, rd);
    endtask

    task automatic register_backpressure();
        logic [31:0] val;
        logic [31:0] rd;
        int          hs;
        for (int i = 0; i < 6; i++) begin
            rng_state = xorshift32(rng_state);
            val = rng_state;
            axi_write(ADDR_SHIFT, val, hs);
            axi_read(ADDR_SHIFT, rd);
            if (rd !== (val & 32'h0000_071F)) report_mismatch("shift", val & 32'h0000_071F, rd);
        end
        axi_read(ADDR_CTRL, rd);
        if (rd !== 32'd0) report_mismatch("ctrl", 32'd0, rd);
    endtask

    task automatic pitch_accuracy();
        int load_cyc;
        play_tune(TEMPO, PITCH, load_cyc);
        build_expected(load_cyc, TEMPO, PITCH);
        wait_until_cycle(note_start(load_cyc, TEMPO, 8) + 2);
        if (edge_q.size() != exp_q.size())
            report_mismatch("piezo_edge_count", exp_q.size(), edge_q.size());
        for (int j = 0; j < edge_q.size() && j < exp_q.size(); j++) begin
            if (edge_q[j] != exp_q[j])
                report_mismatch("piezo_edge_offset", exp_q[j] - load_cyc, edge_q[j] - load_cyc);
        end
    endtask

    task automatic note_lengths_and_order();
        logic [31:0] rd;
        int          load_cyc;
        int          s;
        int          len;
        int          half;
        int          first_e;
        int          last_e;
        play_tune(TEMPO, PITCH, load_cyc);
        for (int i = 0; i < 8; i++) begin
            wait_until_cycle(note_start(load_cyc, TEMPO, i) + (BEATS[i] << TEMPO) / 2);
            axi_read(ADDR_STATUS, rd);
            if (rd !== 32'((i << 4) | 1)) report_mismatch("status", 32'((i << 4) | 1), rd);
        end
        wait_until_cycle(note_start(load_cyc, TEMPO, 8));
        axi_read(ADDR_STATUS, rd);
        if (rd[0] !== 1'b0) report_mismatch("status.busy", 32'd0, {31'd0, rd[0]});
        // Span from the first edge into the gap, for notes that end high
        for (int i = 0; i < 8; i++) begin
            s    = note_start(load_cyc, TEMPO, i);
            len  = BEATS[i] << TEMPO;
            half = HALF_CLKS[MELODY[i]] >> PITCH;
            if (((len - 1) / half) % 2 == 1) begin
                first_e = -1;
                last_e  = -1;
                foreach (edge_q[j]) begin
                    if (edge_q[j] >= s && edge_q[j] <= s + len) begin
                        if (first_e < 0) first_e = edge_q[j];
                        last_e = edge_q[j];
                    end
                end
                if (first_e < 0) begin
                    errors++;
                    $display("No piezo edge seen during note %0d", i);
                end else begin
                    if (first_e - s != half) report_mismatch("note_pitch", half, first_e - s);
                    if (last_e - first_e + half != len)
                        report_mismatch("note_span", len, last_e - first_e + half);
                end
            end
        end
    endtask

    task automatic stop_and_ignored_start();
        logic [31:0] rd;
        int          load_cyc;
        int          hs;
        play_tune(TEMPO, PITCH, load_cyc);
        wait_until_cycle(note_start(load_cyc, TEMPO, 1) + (BEATS[1] << TEMPO) / 2);
        axi_write(ADDR_CTRL, 32'd1, hs); // Second start while busy
        for (int i = 2; i < 4; i++) begin
            wait_until_cycle(note_start(load_cyc, TEMPO, i) + (BEATS[i] << TEMPO) / 2);
            axi_read(ADDR_STATUS, rd);
            if (rd !== 32'((i << 4) | 1)) report_mismatch("status", 32'((i << 4) | 1), rd);
        end
        axi_write(ADDR_CTRL, 32'd2, hs);
        repeat (2) @(negedge clk);
        if (piezo !== 1'b0) report_mismatch("piezo", 32'd0, {31'd0, piezo});
        if (piezo_n !== 1'b1) report_mismatch("piezo_n", 32'd1, {31'd0, piezo_n});
        axi_read(ADDR_STATUS, rd);
        if (rd[0] !== 1'b0) report_mismatch("status.busy", 32'd0, {31'd0, rd[0]});
    endtask

    initial begin
        note_rst_n = 1'b0;
        awaddr     = 4'd0;
        awvalid    = 1'b0;
        wdata      = 32'd0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = 4'd0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        errors     = 0;
        cyc        = 0;
        last_piezo = 1'b0;
        rng_state  = 32'h1570;
        repeat (16) @(posedge clk);
        note_rst_n <= 1'b1;
        verify_reset_state();
        register_backpressure();
        pitch_accuracy();
        note_lengths_and_order();
        stop_and_ignored_start();
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* tune_player.f */
design/tune_pkg.sv
design/axil_tune_regs.sv
design/tune_sequencer.sv
design/dur_timer.sv
design/note_tone_gen.sv
design/tune_player.sv
tests/tune_player_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tune_player_tb
FILELIST  ?= tune_player.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= test passed
VFLAGS    ?= --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only if the pass message shows up as a line of its own
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
